//--- Bender.yml
package:
  name: board_inputs

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/board_pkg.sv
      - rtl/reset_gen.sv
      - rtl/joy_mapper.sv
      - rtl/user_toggles.sv
      - rtl/board_inputs.sv
  - target: test
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/tb_board_inputs.sv

//--- flist.f
+incdir+rtl
+incdir+testbench
rtl/board_pkg.sv
rtl/reset_gen.sv
rtl/joy_mapper.sv
rtl/user_toggles.sv
rtl/board_inputs.sv
testbench/tb_board_inputs.sv

//--- rtl/board_config.svh
// ##########################################################################
// Build-time settings for the arcade board input block
// Bit positions refer to the platform joystick word
// BOARD_BTN_OFFSET moves start, coin and pause up by one for 3-button games
// BOARD_ACTIVE_LOW is a 1-bit literal so it can be replicated into masks
// ##########################################################################
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// reset stretchers release once the counter reaches all ones
`define BOARD_RST_CNT_W     8

`define BOARD_JOY_W         16  // platform joystick word
`define BOARD_GAME_JOY_W    10  // word handed to the game core

// 0 for two-button games, 1 for three-button games
`define BOARD_BTN_OFFSET    1

`define BOARD_START1_BIT    (6 + `BOARD_BTN_OFFSET)
`define BOARD_START2_BIT    (7 + `BOARD_BTN_OFFSET)
`define BOARD_COIN_BIT      (8 + `BOARD_BTN_OFFSET)
`define BOARD_PAUSE_BIT     (9 + `BOARD_BTN_OFFSET)

`define BOARD_GFX_LAYERS    4

// game core expects inverted joystick, coin, start and service
`define BOARD_ACTIVE_LOW    1'b1

`endif

//--- rtl/board_inputs.sv
// ##########################################################################
// Input and reset section of the arcade board wrapper
// All ports belong to the clk_sys domain
// rst is the platform reset and must be synchronous to clk_sys
// sys_rst resets the input logic and game_rst holds the core
// ##########################################################################
`timescale 1ns/10ps

module board_inputs import board_pkg::*; (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         downloading,
    input  logic         rst_req,
    input  logic         dip_flip,
    input  logic         rot_control,
    input  board_joy_t   board_joystick1,
    input  board_joy_t   board_joystick2,
    input  game_joy_t    key_joy1,
    input  game_joy_t    key_joy2,
    input  player_pair_t key_coin,
    input  player_pair_t key_start,
    input  logic         key_pause,
    input  logic         key_reset,
    input  gfx_mask_t    key_gfx,
    input  logic         key_service,
    output logic         sys_rst,
    output logic         sys_rst_n,
    output logic         game_rst,
    output logic         game_rst_n,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output player_pair_t game_coin,
    output player_pair_t game_start,
    output logic         game_pause,
    output gfx_mask_t    gfx_en,
    output logic         game_service
);

    logic joy_pause;
    logic soft_rst;     // reset key back into the game reset

    reset_gen reset_gen_i (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .downloading (downloading),
        .rst_req     (rst_req),
        .dip_flip    (dip_flip),
        .soft_rst    (soft_rst),
        .sys_rst     (sys_rst),
        .sys_rst_n   (sys_rst_n),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

    joy_mapper joy_mapper_i (
        .clk_sys         (clk_sys),
        .sys_rst         (sys_rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_coin        (key_coin),
        .key_start       (key_start),
        .rot_control     (rot_control),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .joy_pause       (joy_pause)
    );

    user_toggles user_toggles_i (
        .clk_sys      (clk_sys),
        .sys_rst      (sys_rst),
        .key_pause    (key_pause),
        .joy_pause    (joy_pause),
        .key_reset    (key_reset),
        .key_gfx      (key_gfx),
        .key_service  (key_service),
        .game_pause   (game_pause),
        .gfx_en       (gfx_en),
        .soft_rst     (soft_rst),
        .game_service (game_service)
    );

endmodule

//--- rtl/board_pkg.sv
// ##########################################################################
// Vector types shared by the board input RTL and its testbench
// Widths come from the config header, so both stay in step
// player_pair_t holds bit 0 for player 1 and bit 1 for player 2
// ##########################################################################
`include "board_config.svh"

package board_pkg;

    // raw joystick word as delivered by the platform
    typedef logic [`BOARD_JOY_W-1:0] board_joy_t;

    // joystick word seen by the game core
    // bits 3..0 are directions, buttons and start/coin/pause above them
    typedef logic [`BOARD_GAME_JOY_W-1:0] game_joy_t;

    // one bit per player, for coin and start
    typedef logic [1:0] player_pair_t;

    // one enable per graphics layer
    typedef logic [`BOARD_GFX_LAYERS-1:0] gfx_mask_t;

    // stretch counter used by both reset generators
    typedef logic [`BOARD_RST_CNT_W-1:0] rst_cnt_t;

endpackage

//--- rtl/joy_mapper.sv
// ##########################################################################
// Joystick, coin and start mapping for the game core
// Platform joysticks pass one register stage before use
// Keys are assumed already synchronous to clk_sys
// rot_control swaps the direction pairs for rotated screens
// Outputs freeze while sys_rst is high and are never cleared
// ##########################################################################
`timescale 1ns/10ps
`include "board_config.svh"

module joy_mapper import board_pkg::*; (
    input  logic         clk_sys,
    input  logic         sys_rst,
    input  board_joy_t   board_joystick1,
    input  board_joy_t   board_joystick2,
    input  game_joy_t    key_joy1,
    input  game_joy_t    key_joy2,
    input  player_pair_t key_coin,
    input  player_pair_t key_start,
    input  logic         rot_control,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output player_pair_t game_coin,
    output player_pair_t game_start,
    output logic         joy_pause      // either player pressed pause
);

    localparam game_joy_t    JOY_INV  = {`BOARD_GAME_JOY_W{`BOARD_ACTIVE_LOW}};
    localparam player_pair_t PAIR_INV = {2{`BOARD_ACTIVE_LOW}};

    board_joy_t   joy1_sync;
    board_joy_t   joy2_sync;
    game_joy_t    joy1_merged;
    game_joy_t    joy2_merged;
    player_pair_t coin_raw;
    player_pair_t start_raw;

    // swap bit 0 with 1 and bit 2 with 3
    function automatic game_joy_t apply_rotation(input game_joy_t joy, input logic rot);
        game_joy_t rotated;
        rotated = joy;
        if (rot) begin
            rotated[0] = joy[1];
            rotated[1] = joy[0];
            rotated[2] = joy[3];
            rotated[3] = joy[2];
        end
        return rotated;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joystick1;
        joy2_sync <= board_joystick2;
    end

    // upper platform bits are not passed to the game
    assign joy1_merged = joy1_sync[`BOARD_GAME_JOY_W-1:0] | key_joy1;
    assign joy2_merged = joy2_sync[`BOARD_GAME_JOY_W-1:0] | key_joy2;

    assign coin_raw = {joy2_sync[`BOARD_COIN_BIT], joy1_sync[`BOARD_COIN_BIT]} | key_coin;

    // either joystick may start either player
    assign start_raw = {joy1_sync[`BOARD_START2_BIT] | joy2_sync[`BOARD_START2_BIT],
                        joy1_sync[`BOARD_START1_BIT] | joy2_sync[`BOARD_START1_BIT]}
                       | key_start;

    assign joy_pause = joy1_sync[`BOARD_PAUSE_BIT] | joy2_sync[`BOARD_PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        if (!sys_rst) begin
            game_joystick1 <= apply_rotation(joy1_merged, rot_control) ^ JOY_INV;
            game_joystick2 <= apply_rotation(joy2_merged, rot_control) ^ JOY_INV;
            game_coin      <= coin_raw ^ PAIR_INV;
            game_start     <= start_raw ^ PAIR_INV;
        end
    end

endmodule

//--- rtl/reset_gen.sv
// ##########################################################################
// System and game reset generation, all on rising clk_sys
// rst must already be synchronous to clk_sys
// Both resets last 256 cycles after the last trigger is seen
// Active-low copies assert one edge after the source and release two
// edges after it, for blocks that use them as async resets
// ##########################################################################
`timescale 1ns/10ps

module reset_gen import board_pkg::*; (
    input  logic clk_sys,
    input  logic rst,           // platform reset
    input  logic downloading,   // ROM load in progress
    input  logic rst_req,       // reset request from the core
    input  logic dip_flip,
    input  logic soft_rst,      // one-cycle pulse from the reset key
    output logic sys_rst,
    output logic sys_rst_n,
    output logic game_rst,
    output logic game_rst_n
);

    rst_cnt_t sys_cnt;
    rst_cnt_t game_cnt;
    logic     last_dip_flip;
    logic     game_trig;
    logic     pre_sys_rst_n;
    logic     pre_game_rst_n;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            sys_cnt <= '0;
            sys_rst <= 1'b1;
        end else if (sys_cnt != '1) begin
            sys_cnt <= sys_cnt + 1'b1;
            sys_rst <= 1'b1;
        end else begin
            sys_rst <= 1'b0;    // counter saturated
        end
    end

    // flipping the screen needs a fresh start of the game
    always_ff @(posedge clk_sys) begin
        last_dip_flip <= dip_flip;
    end

    assign game_trig = sys_rst | downloading | rst_req | soft_rst |
                       (dip_flip != last_dip_flip);

    // any trigger restarts the stretch
    always_ff @(posedge clk_sys) begin
        if (game_trig) begin
            game_cnt <= '0;
            game_rst <= 1'b1;
        end else if (game_cnt != '1) begin
            game_cnt <= game_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // assert early, release through two flops
    always_ff @(posedge clk_sys) begin
        if (sys_rst | downloading) begin
            pre_sys_rst_n <= 1'b0;
            sys_rst_n     <= 1'b0;
        end else begin
            pre_sys_rst_n <= 1'b1;
            sys_rst_n     <= pre_sys_rst_n;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            pre_game_rst_n <= 1'b0;
            game_rst_n     <= 1'b0;
        end else begin
            pre_game_rst_n <= 1'b1;
            game_rst_n     <= pre_game_rst_n;
        end
    end

endmodule

//--- rtl/user_toggles.sv
// ##########################################################################
// User controls that toggle on a key press
// Inputs are level signals synchronous to clk_sys, acted on at rising edges
// Holding a key has no effect beyond the first edge
// A key held through sys_rst gives no edge once reset ends
// ##########################################################################
`timescale 1ns/10ps
`include "board_config.svh"

module user_toggles import board_pkg::*; (
    input  logic      clk_sys,
    input  logic      sys_rst,
    input  logic      key_pause,
    input  logic      joy_pause,
    input  logic      key_reset,
    input  gfx_mask_t key_gfx,
    input  logic      key_service,
    output logic      game_pause,
    output gfx_mask_t gfx_en,       // one bit per graphics layer
    output logic      soft_rst,     // single-cycle pulse
    output logic      game_service
);

    localparam logic SERVICE_INV = `BOARD_ACTIVE_LOW;

    logic      last_pause;
    logic      last_joy_pause;
    logic      last_reset;
    gfx_mask_t last_gfx;
    logic      pause_edge;
    gfx_mask_t gfx_edge;

    // history runs during reset too
    always_ff @(posedge clk_sys) begin
        last_pause     <= key_pause;
        last_joy_pause <= joy_pause;
        last_reset     <= key_reset;
        last_gfx       <= key_gfx;
    end

    assign pause_edge = (key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);
    assign gfx_edge   = key_gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (sys_rst) begin
            game_pause   <= 1'b0;
            gfx_en       <= '1;             // all layers visible
            soft_rst     <= 1'b0;
            game_service <= SERVICE_INV;    // inactive level
        end else begin
            if (pause_edge) begin
                game_pause <= ~game_pause;
            end
            gfx_en       <= gfx_en ^ gfx_edge;
            soft_rst     <= key_reset & ~last_reset;
            game_service <= key_service ^ SERVICE_INV;
        end
    end

endmodule

//--- testbench/board_model.svh
// ##########################################################################
// Reference model for the board input block
// Expected values follow the mapping rules, with polarity from the config
// Meant to be included inside the testbench module after board_pkg import
// A mismatch stops the run at once
// ##########################################################################
`ifndef BOARD_MODEL_SVH
`define BOARD_MODEL_SVH

// left/right and up/down swap places on a rotated screen
function automatic game_joy_t rotate_dirs(input game_joy_t joy, input logic rot);
    if (rot) begin
        return {joy[`BOARD_GAME_JOY_W-1:4], joy[2], joy[3], joy[0], joy[1]};
    end
    return joy;
endfunction

function automatic game_joy_t expected_joy(input board_joy_t board, input game_joy_t key,
                                           input logic rot);
    game_joy_t merged;
    merged = board[`BOARD_GAME_JOY_W-1:0] | key;    // upper platform bits dropped
    return rotate_dirs(merged, rot) ^ {`BOARD_GAME_JOY_W{`BOARD_ACTIVE_LOW}};
endfunction

function automatic player_pair_t expected_coin(input board_joy_t j1, input board_joy_t j2,
                                               input player_pair_t key);
    player_pair_t pressed;
    pressed[0] = j1[`BOARD_COIN_BIT] | key[0];
    pressed[1] = j2[`BOARD_COIN_BIT] | key[1];
    return pressed ^ {2{`BOARD_ACTIVE_LOW}};
endfunction

// start buttons of both sticks count for either player
function automatic player_pair_t expected_start(input board_joy_t j1, input board_joy_t j2,
                                                input player_pair_t key);
    player_pair_t pressed;
    pressed[0] = j1[`BOARD_START1_BIT] | j2[`BOARD_START1_BIT] | key[0];
    pressed[1] = j1[`BOARD_START2_BIT] | j2[`BOARD_START2_BIT] | key[1];
    return pressed ^ {2{`BOARD_ACTIVE_LOW}};
endfunction

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "run stopped");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
endtask

`endif

//--- testbench/tb_board_inputs.sv
// ##########################################################################
// Testbench for board_inputs
// Inputs change and outputs are sampled on the falling clk_sys edge
// Random stimulus repeats from a fixed seed
// Joystick pause bits stay clear outside the toggle test, so the pause
// model starts from its reset value there
// ##########################################################################
`timescale 1ns/10ps
`include "board_config.svh"

module tb_board_inputs import board_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int RST_CYCLES    = 8;
    localparam int RST_LEN       = 1 << `BOARD_RST_CNT_W;
    localparam int HOLD_CYCLES   = 4;
    localparam int JOY_ROUNDS    = 40;
    localparam int PAIR_ROUNDS   = 40;
    localparam int TOGGLE_ROUNDS = 60;
    // power-on takes two stretches, the three triggers and the reset key one each
    localparam int TEST_CYCLES   = RST_CYCLES + 6 * (RST_LEN + 8) +
                                   (JOY_ROUNDS + PAIR_ROUNDS + TOGGLE_ROUNDS) * HOLD_CYCLES;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

    localparam int SEL_SYS_RST    = 0;
    localparam int SEL_SYS_RST_N  = 1;
    localparam int SEL_GAME_RST   = 2;
    localparam int SEL_GAME_RST_N = 3;

    // only the bits that feed coin and start
    localparam board_joy_t PAIR_MASK = (1 << `BOARD_COIN_BIT) | (1 << `BOARD_START1_BIT) |
                                       (1 << `BOARD_START2_BIT);

    logic         clk_sys;
    logic         rst;
    logic         downloading;
    logic         rst_req;
    logic         dip_flip;
    logic         rot_control;
    board_joy_t   board_joystick1;
    board_joy_t   board_joystick2;
    game_joy_t    key_joy1;
    game_joy_t    key_joy2;
    player_pair_t key_coin;
    player_pair_t key_start;
    logic         key_pause;
    logic         key_reset;
    gfx_mask_t    key_gfx;
    logic         key_service;
    logic         sys_rst;
    logic         sys_rst_n;
    logic         game_rst;
    logic         game_rst_n;
    game_joy_t    game_joystick1;
    game_joy_t    game_joystick2;
    player_pair_t game_coin;
    player_pair_t game_start;
    logic         game_pause;
    gfx_mask_t    gfx_en;
    logic         game_service;

    integer seed = 77;
    int     edge_cnt = 0;   // rising edges seen so far

    board_inputs dut_i (.*);

    `include "board_model.svh"

    initial begin
        clk_sys = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
        end
    end

    always @(posedge clk_sys) edge_cnt <= edge_cnt + 1;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout: the test sequence did not finish in the expected time");
    end

    function automatic logic probe(input int sel);
        case (sel)
            SEL_SYS_RST:   return sys_rst;
            SEL_SYS_RST_N: return sys_rst_n;
            SEL_GAME_RST:  return game_rst;
            default:       return game_rst_n;
        endcase
    endfunction

    // steps falling edges until the chosen reset shows level
    task automatic await_level(input int sel, input logic level, input int limit,
                               input string what, output int seen_at);
        int waited;
        waited = 0;
        while (probe(sel) !== level) begin
            if (waited >= limit) begin
                abort_run($sformatf("%s did not reach %0b within %0d cycles",
                                    what, level, limit));
            end else begin
                @(negedge clk_sys);
                waited++;
            end
        end
        seen_at = edge_cnt;
    endtask

    task automatic power_on_reset();
        int released;
        int sys_fall;
        int game_fall;
        int seen;
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        released = edge_cnt;    // last edge that sampled rst high
        await_level(SEL_SYS_RST, 1'b0, RST_LEN + 4, "sys_rst", sys_fall);
        check_value("power-on sys_rst length", RST_LEN, sys_fall - released);
        await_level(SEL_SYS_RST_N, 1'b1, 4, "sys_rst_n", seen);
        check_value("power-on sys_rst_n release", 2, seen - sys_fall);
        await_level(SEL_GAME_RST, 1'b0, RST_LEN + 4, "game_rst", game_fall);
        check_value("power-on game_rst length", RST_LEN, game_fall - sys_fall);
        await_level(SEL_GAME_RST_N, 1'b1, 4, "game_rst_n", seen);
        check_value("power-on game_rst_n release", 2, seen - game_fall);
    endtask

    // kind 0 pulses rst_req, kind 1 toggles dip_flip, kind 2 holds downloading
    task automatic game_reset_trigger(input int kind, input string name);
        int last_trig;
        int fall;
        int seen;
        case (kind)
            0:       rst_req = 1'b1;
            1:       dip_flip = ~dip_flip;
            default: downloading = 1'b1;
        endcase
        @(negedge clk_sys);
        check_value({name, " game_rst rise"}, 1, game_rst);
        check_value({name, " game_rst_n still high"}, 1, game_rst_n);
        check_value({name, " sys_rst_n"}, (kind == 2) ? 0 : 1, sys_rst_n);
        rst_req = 1'b0;
        last_trig = edge_cnt;
        @(negedge clk_sys);
        check_value({name, " game_rst_n assert"}, 0, game_rst_n);
        if (kind == 2) begin
            repeat (4) @(negedge clk_sys);
            downloading = 1'b0;
            last_trig = edge_cnt;
            await_level(SEL_SYS_RST_N, 1'b1, 4, "sys_rst_n", seen);
            check_value({name, " sys_rst_n release"}, 2, seen - last_trig);
        end
        await_level(SEL_GAME_RST, 1'b0, RST_LEN + 4, "game_rst", fall);
        check_value({name, " game_rst length"}, RST_LEN, fall - last_trig);
        await_level(SEL_GAME_RST_N, 1'b1, 4, "game_rst_n", seen);
        check_value({name, " game_rst_n release"}, 2, seen - fall);
    endtask

    task automatic joystick_mapping();
        repeat (JOY_ROUNDS) begin
            board_joystick1 = $random(seed);
            board_joystick2 = $random(seed);
            board_joystick1[`BOARD_PAUSE_BIT] = 1'b0;
            board_joystick2[`BOARD_PAUSE_BIT] = 1'b0;
            key_joy1 = $random(seed) & $random(seed);   // sparse keys
            key_joy2 = $random(seed) & $random(seed);
            rot_control = $random(seed);
            repeat (HOLD_CYCLES) @(negedge clk_sys);
            check_value("joystick mapping player 1",
                        expected_joy(board_joystick1, key_joy1, rot_control), game_joystick1);
            check_value("joystick mapping player 2",
                        expected_joy(board_joystick2, key_joy2, rot_control), game_joystick2);
        end
        key_joy1 = '0;
        key_joy2 = '0;
    endtask

    task automatic coin_and_start();
        repeat (PAIR_ROUNDS) begin
            board_joystick1 = $random(seed) & PAIR_MASK;
            board_joystick2 = $random(seed) & PAIR_MASK;
            key_coin = $random(seed);
            key_start = $random(seed);
            repeat (HOLD_CYCLES) @(negedge clk_sys);
            check_value("coin", expected_coin(board_joystick1, board_joystick2, key_coin),
                        game_coin);
            check_value("start", expected_start(board_joystick1, board_joystick2, key_start),
                        game_start);
        end
        key_coin = '0;
        key_start = '0;
    endtask

    task automatic toggle_controls();
        logic      pause_m;
        gfx_mask_t gfx_m;
        logic      prev_kp;
        logic      prev_jp;
        gfx_mask_t prev_kg;
        logic      jp;
        pause_m = 1'b0;     // values left by sys_rst
        gfx_m = '1;
        prev_kp = 1'b0;
        prev_jp = 1'b0;
        prev_kg = '0;
        repeat (TOGGLE_ROUNDS) begin
            key_pause = $random(seed);
            key_gfx = $random(seed);
            key_service = $random(seed);
            board_joystick1 = '0;
            board_joystick2 = '0;
            board_joystick1[`BOARD_PAUSE_BIT] = $random(seed);
            board_joystick2[`BOARD_PAUSE_BIT] = $random(seed);
            jp = board_joystick1[`BOARD_PAUSE_BIT] | board_joystick2[`BOARD_PAUSE_BIT];
            // stick pause arrives a clock after the key, so both edges count
            pause_m = pause_m ^ (key_pause & ~prev_kp) ^ (jp & ~prev_jp);
            gfx_m = gfx_m ^ (key_gfx & ~prev_kg);
            prev_kp = key_pause;
            prev_jp = jp;
            prev_kg = key_gfx;
            repeat (HOLD_CYCLES) @(negedge clk_sys);
            check_value("pause toggle", pause_m, game_pause);
            check_value("graphics layer toggle", gfx_m, gfx_en);
            check_value("service level", key_service ^ `BOARD_ACTIVE_LOW, game_service);
        end
        key_pause = 1'b0;
        key_gfx = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
    endtask

    task automatic soft_reset_key();
        int rise;
        int fall;
        key_reset = 1'b1;   // held for the whole stretch
        await_level(SEL_GAME_RST, 1'b1, 3, "game_rst after the reset key", rise);
        await_level(SEL_GAME_RST, 1'b0, RST_LEN + 4, "game_rst", fall);
        check_value("soft reset hold", RST_LEN, fall - rise);
        key_reset = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        downloading = 1'b0;
        rst_req = 1'b0;
        dip_flip = 1'b0;
        rot_control = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        key_joy1 = '0;
        key_joy2 = '0;
        key_coin = '0;
        key_start = '0;
        key_pause = 1'b0;
        key_reset = 1'b0;
        key_gfx = '0;
        key_service = 1'b0;
        power_on_reset();
        game_reset_trigger(0, "rst_req pulse");
        game_reset_trigger(1, "dip_flip toggle");
        game_reset_trigger(2, "downloading");
        joystick_mapping();
        coin_and_start();
        toggle_controls();
        soft_reset_key();
        $display("** PASS **");
        $finish;
    end

endmodule
